//--- testbench/decode_vectors.txt
# W rd data | F flush | I inst rd rd_wen rs1_data rs2_data imm alu csr src_sel lsu funct3
# all fields hex, a W right after an I lands in the cycle that I reads its registers
W 01 11111111
W 02 22222222
W 03 80000003
W 00 ffffffff
I ffd08293 05 1 11111111 00000000 fffffffd 0001 00 0 0 0
I 40208333 06 1 11111111 22222222 00000000 0002 00 1 0 0
I 4011d3b3 07 1 80000003 11111111 00000000 4880 00 1 0 5
I 02208433 08 1 11111111 22222222 00000000 1000 00 1 0 0
I 021154b3 09 1 22222222 11111111 00000000 6800 00 1 0 5
I abcde537 0a 1 00000000 00000000 abcde000 8001 00 0 0 6
I 00001597 0b 1 00000000 00000000 00001000 4c00 00 3 0 1
I ff9ff0ef 01 1 00000000 00000000 fffffff8 cc00 00 0 0 7
I 00209863 00 0 11111111 22222222 00000010 4802 00 3 0 1
I fe11fee3 00 0 80000003 11111111 fffffffc c810 00 3 0 7
I 00812603 0c 1 22222222 00000000 00000008 8000 00 0 1 2
I fe30ae23 00 0 11111111 80000003 fffffffc 8000 00 0 2 2
I 00000073 00 1 00000000 00000000 00000000 0000 01 0 0 0
I 30200073 00 1 00000000 00000000 00006040 0000 02 0 0 0
I 3002e6f3 0d 1 00000000 00000000 00006005 8000 14 0 0 6
I 34109773 0e 1 11111111 00000000 00006821 4800 08 0 0 1
I 000207b3 0f 1 deadbeef 00000000 00000000 0001 00 1 0 0
W 04 deadbeef
I 0ff0c813 10 1 11111111 00000000 000000ff 0020 00 0 0 4
F
I fff17893 11 1 22222222 00000000 ffffffff ca00 00 0 0 7

//--- build.f
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/inst_predecode.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
testbench/decode_properties.sv
testbench/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage -f build.f
./obj_dir/Vtb_decode_stage > sim.log 2>&1
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

//--- testbench/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

	localparam int EXP_W = rv_isa_pkg::REG_W + 1 + 3 * rv_isa_pkg::XLEN + rv_ctrl_pkg::ALU_OPT_W
		+ rv_ctrl_pkg::CSR_OPT_W + rv_ctrl_pkg::SRC_SEL_W + rv_ctrl_pkg::LSU_OPT_W + 3;

	logic                              clk;
	logic                              rst;
	logic                              inst_valid;
	logic [rv_isa_pkg::XLEN-1:0]       inst;
	logic                              stall;
	logic                              flush;
	logic                              wb_wen;
	logic [rv_isa_pkg::REG_W-1:0]      wb_rd;
	logic [rv_isa_pkg::XLEN-1:0]       wb_data;
	logic                              ex_valid;
	logic [rv_isa_pkg::REG_W-1:0]      ex_rd;
	logic                              ex_rd_wen;
	logic [rv_isa_pkg::XLEN-1:0]       ex_rs1_data;
	logic [rv_isa_pkg::XLEN-1:0]       ex_rs2_data;
	logic [rv_isa_pkg::XLEN-1:0]       ex_imm;
	logic [rv_ctrl_pkg::ALU_OPT_W-1:0] ex_alu_opt;
	logic [rv_ctrl_pkg::CSR_OPT_W-1:0] ex_csr_opt;
	logic [rv_ctrl_pkg::SRC_SEL_W-1:0] ex_src_sel;
	logic [rv_ctrl_pkg::LSU_OPT_W-1:0] ex_lsu_opt;
	logic [2:0]                        ex_funct3;

	logic [EXP_W-1:0] exp_q [$];
	logic [15:0]      lfsr_state;
	int               errors;
	int               checks;

	decode_stage DUT (
		.clk         (clk),
		.rst         (rst),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.stall       (stall),
		.flush       (flush),
		.wb_wen      (wb_wen),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.ex_valid    (ex_valid),
		.ex_rd       (ex_rd),
		.ex_rd_wen   (ex_rd_wen),
		.ex_rs1_data (ex_rs1_data),
		.ex_rs2_data (ex_rs2_data),
		.ex_imm      (ex_imm),
		.ex_alu_opt  (ex_alu_opt),
		.ex_csr_opt  (ex_csr_opt),
		.ex_src_sel  (ex_src_sel),
		.ex_lsu_opt  (ex_lsu_opt),
		.ex_funct3   (ex_funct3)
	);

	always #10 clk = ~clk;

	// galois form, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? 16'hB400 : 16'h0000);
		return out;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("mismatch %s exp %h got %h", name, exp, got);
		end
	endtask

	// one idle cycle with all strobes low
	task automatic drive_idle();
		@(posedge clk);
		inst_valid <= 1'b0;
		stall      <= 1'b0;
		flush      <= 1'b0;
		wb_wen     <= 1'b0;
	endtask

	// keeps offering the word until a cycle without stall takes it
	task automatic send_inst(input logic [31:0] word);
		int  tries;
		logic st;
		tries = 0;
		st = 1'b1;
		while (st) begin
			@(posedge clk);
			st = (tries < 15) ? (lfsr_step() & lfsr_step()) : 1'b0;
			inst_valid <= 1'b1;
			inst       <= word;
			stall      <= st;
			flush      <= 1'b0;
			wb_wen     <= 1'b0;
			tries++;
		end
	endtask

	// no stall here, so a write right after an instruction meets its read
	task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
		@(posedge clk);
		inst_valid <= 1'b0;
		stall      <= 1'b0;
		flush      <= 1'b0;
		wb_wen     <= 1'b1;
		wb_rd      <= rd;
		wb_data    <= data;
	endtask

	task automatic flush_pipe();
		@(posedge clk);
		inst_valid <= 1'b0;
		stall      <= 1'b0;
		flush      <= 1'b1;
		wb_wen     <= 1'b0;
		drive_idle();
		@(negedge clk);
		// whatever was in flight is gone
		exp_q.delete();
	endtask

	// an instruction retires on an edge where stall is low
	always @(posedge clk) begin
		logic [rv_isa_pkg::REG_W-1:0]      e_rd;
		logic                              e_wen;
		logic [rv_isa_pkg::XLEN-1:0]       e_rs1;
		logic [rv_isa_pkg::XLEN-1:0]       e_rs2;
		logic [rv_isa_pkg::XLEN-1:0]       e_imm;
		logic [rv_ctrl_pkg::ALU_OPT_W-1:0] e_alu;
		logic [rv_ctrl_pkg::CSR_OPT_W-1:0] e_csr;
		logic [rv_ctrl_pkg::SRC_SEL_W-1:0] e_src;
		logic [rv_ctrl_pkg::LSU_OPT_W-1:0] e_lsu;
		logic [2:0]                        e_f3;
		if (!rst && ex_valid && !stall) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ex_valid went high with no instruction expected");
			end else begin
				{e_rd, e_wen, e_rs1, e_rs2, e_imm, e_alu, e_csr, e_src, e_lsu, e_f3} =
					exp_q.pop_front();
				check("ex_rd", e_rd, ex_rd);
				check("ex_rd_wen", e_wen, ex_rd_wen);
				check("ex_rs1_data", e_rs1, ex_rs1_data);
				check("ex_rs2_data", e_rs2, ex_rs2_data);
				check("ex_imm", e_imm, ex_imm);
				check("ex_alu_opt", e_alu, ex_alu_opt);
				check("ex_csr_opt", e_csr, ex_csr_opt);
				check("ex_src_sel", e_src, ex_src_sel);
				check("ex_lsu_opt", e_lsu, ex_lsu_opt);
				check("ex_funct3", e_f3, ex_funct3);
			end
		end
	end

	initial begin
		int          fd;
		int          n;
		int          cycles;
		string       line;
		logic [31:0] v [0:10];
		clk        = 1'b0;
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		stall      = 1'b0;
		flush      = 1'b0;
		wb_wen     = 1'b0;
		wb_rd      = '0;
		wb_data    = '0;
		lfsr_state = 16'd43163;
		errors     = 0;
		checks     = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("testbench/decode_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the vector file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() == 0) begin
					continue;
				end
				if (line[0] == "W") begin
					n = $sscanf(line, "W %h %h", v[0], v[1]);
					write_reg(v[0][4:0], v[1]);
				end else if (line[0] == "F") begin
					flush_pipe();
				end else if (line[0] == "I") begin
					n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
						v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
					if (n != 11) begin
						errors++;
						$display("badly formed instruction line in the vector file");
					end
					exp_q.push_back({v[1][rv_isa_pkg::REG_W-1:0], v[2][0], v[3], v[4], v[5],
						v[6][rv_ctrl_pkg::ALU_OPT_W-1:0], v[7][rv_ctrl_pkg::CSR_OPT_W-1:0],
						v[8][rv_ctrl_pkg::SRC_SEL_W-1:0], v[9][rv_ctrl_pkg::LSU_OPT_W-1:0],
						v[10][2:0]});
					send_inst(v[0]);
				end
			end
			$fclose(fd);
		end
		cycles = 0;
		while (exp_q.size() > 0 && cycles < 40) begin
			drive_idle();
			cycles++;
		end
		if (exp_q.size() > 0) begin
			errors++;
			$display("timed out waiting for ex_valid, %0d instructions never came out",
				exp_q.size());
		end
		repeat (4) drive_idle();
		// failures of the bound properties count as errors too
		if (DUT.u_properties.fail_count != 0) begin
			errors += DUT.u_properties.fail_count;
			$display("bound assertions failed %0d times", DUT.u_properties.fail_count);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/decode_properties.sv
`timescale 1ns/10ps
`default_nettype none

module decode_properties (
	input logic                              clk,
	input logic                              rst,
	input logic                              stall,
	input logic                              flush,
	input logic                              ex_valid,
	input logic                              ex_rd_wen,
	input logic [rv_isa_pkg::REG_W-1:0]      ex_rd,
	input logic [rv_isa_pkg::XLEN-1:0]       ex_rs1_data,
	input logic [rv_isa_pkg::XLEN-1:0]       ex_rs2_data,
	input logic [rv_isa_pkg::XLEN-1:0]       ex_imm,
	input logic [rv_ctrl_pkg::ALU_OPT_W-1:0] ex_alu_opt,
	input logic [rv_ctrl_pkg::CSR_OPT_W-1:0] ex_csr_opt,
	input logic [rv_ctrl_pkg::SRC_SEL_W-1:0] ex_src_sel,
	input logic [rv_ctrl_pkg::LSU_OPT_W-1:0] ex_lsu_opt,
	input logic [2:0]                        ex_funct3
);

	int fail_count = 0;

	// reset and flush both leave a bubble
	a_clear: assert property (@(posedge clk) (rst || flush) |=> !ex_valid)
		else begin
			fail_count++;
			$error("ex_valid high after reset or flush");
		end

	a_wen_valid: assert property (@(posedge clk) disable iff (rst) ex_rd_wen |-> ex_valid)
		else begin
			fail_count++;
			$error("ex_rd_wen high without ex_valid");
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(stall && !flush) |=> $stable({ex_valid, ex_rd_wen, ex_rd, ex_rs1_data, ex_rs2_data,
			ex_imm, ex_alu_opt, ex_csr_opt, ex_src_sel, ex_lsu_opt, ex_funct3}))
		else begin
			fail_count++;
			$error("execute outputs changed during stall");
		end

endmodule

bind decode_stage decode_properties u_properties (.*);

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              inst_valid,
	input  logic [rv_isa_pkg::XLEN-1:0]       inst,
	input  logic                              stall,
	input  logic                              flush,
	input  logic                              wb_wen,
	input  logic [rv_isa_pkg::REG_W-1:0]      wb_rd,
	input  logic [rv_isa_pkg::XLEN-1:0]       wb_data,
	output logic                              ex_valid,
	output logic [rv_isa_pkg::REG_W-1:0]      ex_rd,
	output logic                              ex_rd_wen,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_rs1_data,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_rs2_data,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_imm,
	output logic [rv_ctrl_pkg::ALU_OPT_W-1:0] ex_alu_opt,
	output logic [rv_ctrl_pkg::CSR_OPT_W-1:0] ex_csr_opt,
	output logic [rv_ctrl_pkg::SRC_SEL_W-1:0] ex_src_sel,
	output logic [rv_ctrl_pkg::LSU_OPT_W-1:0] ex_lsu_opt,
	output logic [2:0]                        ex_funct3
);

	logic                              pd_valid;
	logic [rv_isa_pkg::XLEN-1:0]       pd_inst;
	logic                              pd_jal;
	logic                              pd_jalr;
	logic                              pd_branch;
	logic                              pd_sys;
	logic                              pd_ecall;
	logic                              pd_mret;
	logic [rv_isa_pkg::REG_W-1:0]      rd;
	logic                              rd_wen;
	logic [rv_isa_pkg::REG_W-1:0]      rs1;
	logic [rv_isa_pkg::REG_W-1:0]      rs2;
	logic [rv_isa_pkg::XLEN-1:0]       imm;
	logic [rv_ctrl_pkg::ALU_OPT_W-1:0] alu_opt_bus;
	logic [rv_ctrl_pkg::CSR_OPT_W-1:0] csr_opt_bus;
	logic [rv_ctrl_pkg::SRC_SEL_W-1:0] src_sel;
	logic [rv_ctrl_pkg::LSU_OPT_W-1:0] lsu_opt;
	logic [2:0]                        funct3;
	logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
	logic [rv_isa_pkg::XLEN-1:0]       rs2_data;

	inst_predecode u_predecode (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.flush      (flush),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pd_valid   (pd_valid),
		.pd_inst    (pd_inst),
		.pd_jal     (pd_jal),
		.pd_jalr    (pd_jalr),
		.pd_branch  (pd_branch),
		.pd_sys     (pd_sys),
		.pd_ecall   (pd_ecall),
		.pd_mret    (pd_mret)
	);

	inst_decode u_decode (
		.inst          (pd_inst),
		.idu_jal       (pd_jal),
		.idu_jalr      (pd_jalr),
		.idu_branch    (pd_branch),
		.idu_sys       (pd_sys),
		.idu_csr_ecall (pd_ecall),
		.idu_csr_mret  (pd_mret),
		.rd            (rd),
		.rd_wen        (rd_wen),
		.rs1           (rs1),
		.rs2           (rs2),
		.imm           (imm),
		.alu_opt_bus   (alu_opt_bus),
		.csr_opt_bus   (csr_opt_bus),
		.src_sel       (src_sel),
		.lsu_opt       (lsu_opt),
		.funct3        (funct3)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.wen    (wb_wen),
		.waddr  (wb_rd),
		.wdata  (wb_data),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	id_ex_reg u_id_ex (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.flush       (flush),
		.in_valid    (pd_valid),
		.rd          (rd),
		.rd_wen      (rd_wen),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.imm         (imm),
		.alu_opt     (alu_opt_bus),
		.csr_opt     (csr_opt_bus),
		.src_sel     (src_sel),
		.lsu_opt     (lsu_opt),
		.funct3      (funct3),
		.ex_valid    (ex_valid),
		.ex_rd       (ex_rd),
		.ex_rd_wen   (ex_rd_wen),
		.ex_rs1_data (ex_rs1_data),
		.ex_rs2_data (ex_rs2_data),
		.ex_imm      (ex_imm),
		.ex_alu_opt  (ex_alu_opt),
		.ex_csr_opt  (ex_csr_opt),
		.ex_src_sel  (ex_src_sel),
		.ex_lsu_opt  (ex_lsu_opt),
		.ex_funct3   (ex_funct3)
	);

endmodule

`default_nettype wire

//--- hdl/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              stall,
	input  logic                              flush,
	input  logic                              in_valid,
	input  logic [rv_isa_pkg::REG_W-1:0]      rd,
	input  logic                              rd_wen,
	input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
	input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
	input  logic [rv_isa_pkg::XLEN-1:0]       imm,
	input  logic [rv_ctrl_pkg::ALU_OPT_W-1:0] alu_opt,
	input  logic [rv_ctrl_pkg::CSR_OPT_W-1:0] csr_opt,
	input  logic [rv_ctrl_pkg::SRC_SEL_W-1:0] src_sel,
	input  logic [rv_ctrl_pkg::LSU_OPT_W-1:0] lsu_opt,
	input  logic [2:0]                        funct3,
	output logic                              ex_valid,
	output logic [rv_isa_pkg::REG_W-1:0]      ex_rd,
	output logic                              ex_rd_wen,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_rs1_data,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_rs2_data,
	output logic [rv_isa_pkg::XLEN-1:0]       ex_imm,
	output logic [rv_ctrl_pkg::ALU_OPT_W-1:0] ex_alu_opt,
	output logic [rv_ctrl_pkg::CSR_OPT_W-1:0] ex_csr_opt,
	output logic [rv_ctrl_pkg::SRC_SEL_W-1:0] ex_src_sel,
	output logic [rv_ctrl_pkg::LSU_OPT_W-1:0] ex_lsu_opt,
	output logic [2:0]                        ex_funct3
);

	// a bubble never writes a register or memory
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ex_valid   <= 1'b0;
			ex_rd_wen  <= 1'b0;
			ex_lsu_opt <= '0;
		end else if (!stall) begin
			ex_valid   <= in_valid;
			ex_rd_wen  <= in_valid & rd_wen;
			ex_lsu_opt <= in_valid ? lsu_opt : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_rd       <= rd;
			ex_rs1_data <= rs1_data;
			ex_rs2_data <= rs2_data;
			ex_imm      <= imm;
			ex_alu_opt  <= alu_opt;
			ex_csr_opt  <= csr_opt;
			ex_src_sel  <= src_sel;
			ex_funct3   <= funct3;
		end
	end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wen,
	input  logic [rv_isa_pkg::REG_W-1:0] waddr,
	input  logic [rv_isa_pkg::XLEN-1:0]  wdata,
	input  logic [rv_isa_pkg::REG_W-1:0] raddr1,
	input  logic [rv_isa_pkg::REG_W-1:0] raddr2,
	output logic [rv_isa_pkg::XLEN-1:0]  rdata1,
	output logic [rv_isa_pkg::XLEN-1:0]  rdata2
);

	logic [rv_isa_pkg::XLEN-1:0] regs [0:2**rv_isa_pkg::REG_W-1];

	// x0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**rv_isa_pkg::REG_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// same-cycle writeback bypasses the array
	function automatic logic [rv_isa_pkg::XLEN-1:0] read_port(
		input logic [rv_isa_pkg::REG_W-1:0] addr
	);
		if (addr == '0) begin
			return '0;
		end else if (wen && (addr == waddr)) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

`default_nettype wire

//--- hdl/inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
	input  rv_isa_pkg::inst_u                 inst,
	input  logic                              idu_jal,
	input  logic                              idu_jalr,
	input  logic                              idu_branch,
	input  logic                              idu_sys,
	input  logic                              idu_csr_ecall,
	input  logic                              idu_csr_mret,
	output logic [rv_isa_pkg::REG_W-1:0]      rd,
	output logic                              rd_wen,
	output logic [rv_isa_pkg::REG_W-1:0]      rs1,
	output logic [rv_isa_pkg::REG_W-1:0]      rs2,
	output logic [rv_isa_pkg::XLEN-1:0]       imm,
	output logic [rv_ctrl_pkg::ALU_OPT_W-1:0] alu_opt_bus,
	output logic [rv_ctrl_pkg::CSR_OPT_W-1:0] csr_opt_bus,
	output logic [rv_ctrl_pkg::SRC_SEL_W-1:0] src_sel,
	output logic [rv_ctrl_pkg::LSU_OPT_W-1:0] lsu_opt,
	output logic [2:0]                        funct3
);

	logic [6:0] opcode;
	logic m_ext;
	logic alt;
	logic is_lui;
	logic is_auipc;
	logic is_load;
	logic is_store;
	logic is_op_imm;
	logic is_op;
	logic is_op_base;
	logic is_fence;
	logic fmt_i;
	logic fmt_u;
	logic [rv_isa_pkg::XLEN-1:0] imm_i;
	logic [rv_isa_pkg::XLEN-1:0] imm_s;
	logic [rv_isa_pkg::XLEN-1:0] imm_b;
	logic [rv_isa_pkg::XLEN-1:0] imm_u;
	logic [rv_isa_pkg::XLEN-1:0] imm_j;
	logic [rv_isa_pkg::XLEN-1:0] imm_csr;

	assign opcode = inst.r.opcode;
	assign funct3 = inst.r.funct3;
	// funct7[0] marks the M extension, funct7[5] sub and sra
	assign m_ext  = inst.r.funct7[0];
	assign alt    = inst.r.funct7[5];

	assign is_lui     = (opcode == rv_isa_pkg::OP_LUI);
	assign is_auipc   = (opcode == rv_isa_pkg::OP_AUIPC);
	assign is_load    = (opcode == rv_isa_pkg::OP_LOAD);
	assign is_store   = (opcode == rv_isa_pkg::OP_STORE);
	assign is_op_imm  = (opcode == rv_isa_pkg::OP_IMM);
	assign is_op      = (opcode == rv_isa_pkg::OP_OP);
	assign is_fence   = (opcode == rv_isa_pkg::OP_FENCE);
	assign is_op_base = is_op & ~m_ext;

	assign fmt_i = idu_jalr | is_load | is_op_imm | idu_sys;
	assign fmt_u = is_lui | is_auipc;

	// indices the format does not carry read as x0
	assign rd_wen = fmt_u | idu_jal | fmt_i | is_op;
	assign rd     = rd_wen ? inst.r.rd : '0;
	assign rs1    = (fmt_i | idu_branch | is_store | is_op) ? inst.r.rs1 : '0;
	assign rs2    = (idu_branch | is_store | is_op) ? inst.r.rs2 : '0;

	assign imm_i = {{(rv_isa_pkg::XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{(rv_isa_pkg::XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5,
		inst.s.imm_4_0};
	assign imm_b = {{(rv_isa_pkg::XLEN-12){inst.b.imm_12}}, inst.b.imm_11,
		inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'd0};
	assign imm_j = {{(rv_isa_pkg::XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};
	// csr address above zimm, both unsigned
	assign imm_csr = {{(rv_isa_pkg::XLEN-17){1'b0}}, inst.i.imm_11_0, inst.i.rs1};

	always_comb begin
		if (idu_sys) begin
			imm = imm_csr;
		end else if (fmt_i | is_fence) begin
			// fence keeps fm, pred and succ here
			imm = imm_i;
		end else if (fmt_u) begin
			imm = imm_u;
		end else if (idu_jal) begin
			imm = imm_j;
		end else if (idu_branch) begin
			imm = imm_b;
		end else if (is_store) begin
			imm = imm_s;
		end else begin
			imm = '0;
		end
	end

	always_comb begin
		alu_opt_bus = '0;
		alu_opt_bus[rv_ctrl_pkg::ALU_ADD]         = is_lui;
		alu_opt_bus[rv_ctrl_pkg::ALU_PC]          = is_auipc | idu_jal | idu_jalr;
		alu_opt_bus[rv_ctrl_pkg::ALU_BRU]         = funct3[0];
		alu_opt_bus[rv_ctrl_pkg::ALU_MUL]         = is_op & m_ext & ~funct3[2];
		alu_opt_bus[rv_ctrl_pkg::ALU_DIV]         = is_op & m_ext & funct3[2];
		alu_opt_bus[rv_ctrl_pkg::ALU_MULDIV_BIT0] = funct3[0];
		alu_opt_bus[rv_ctrl_pkg::ALU_MULDIV_BIT1] = funct3[1];
		// branches compare, bru flips the sense
		if (idu_branch) begin
			case (funct3[2:1])
				2'b00:   alu_opt_bus[rv_ctrl_pkg::ALU_SUB]  = 1'b1;
				2'b10:   alu_opt_bus[rv_ctrl_pkg::ALU_SLT]  = 1'b1;
				2'b11:   alu_opt_bus[rv_ctrl_pkg::ALU_SLTU] = 1'b1;
				default: alu_opt_bus[rv_ctrl_pkg::ALU_SUB]  = 1'b0;
			endcase
		end
		if (is_op_imm | is_op_base) begin
			case (funct3)
				3'b000: begin
					if (is_op_base & alt) begin
						alu_opt_bus[rv_ctrl_pkg::ALU_SUB] = 1'b1;
					end else begin
						alu_opt_bus[rv_ctrl_pkg::ALU_ADD] = 1'b1;
					end
				end
				3'b001:  alu_opt_bus[rv_ctrl_pkg::ALU_SLL]  = 1'b1;
				3'b010:  alu_opt_bus[rv_ctrl_pkg::ALU_SLT]  = 1'b1;
				3'b011:  alu_opt_bus[rv_ctrl_pkg::ALU_SLTU] = 1'b1;
				3'b100:  alu_opt_bus[rv_ctrl_pkg::ALU_XOR]  = 1'b1;
				3'b101: begin
					alu_opt_bus[rv_ctrl_pkg::ALU_SRA] = alt;
					alu_opt_bus[rv_ctrl_pkg::ALU_SRL] = ~alt;
				end
				3'b110:  alu_opt_bus[rv_ctrl_pkg::ALU_OR]   = 1'b1;
				default: alu_opt_bus[rv_ctrl_pkg::ALU_AND]  = 1'b1;
			endcase
		end
	end

	// csrrw, csrrs, csrrc and their zimm forms
	always_comb begin
		csr_opt_bus = '0;
		csr_opt_bus[rv_ctrl_pkg::CSR_ECALL] = idu_csr_ecall;
		csr_opt_bus[rv_ctrl_pkg::CSR_MRET]  = idu_csr_mret;
		csr_opt_bus[rv_ctrl_pkg::CSR_ZIMM]  = idu_sys & funct3[2];
		csr_opt_bus[rv_ctrl_pkg::CSR_01]    = idu_sys & (funct3[1:0] == 2'b01);
		csr_opt_bus[rv_ctrl_pkg::CSR_10]    = idu_sys & (funct3[1:0] == 2'b10);
		csr_opt_bus[rv_ctrl_pkg::CSR_11]    = idu_sys & (funct3[1:0] == 2'b11);
	end

	always_comb begin
		if (is_auipc | idu_branch) begin
			src_sel = rv_ctrl_pkg::SRC_SEL_IMM_SRC2;
		end else if (is_op) begin
			src_sel = rv_ctrl_pkg::SRC_SEL_4_SRC2;
		end else begin
			src_sel = rv_ctrl_pkg::SRC_SEL_4_IMM;
		end
	end

	assign lsu_opt = {is_store, is_load};

endmodule

`default_nettype wire

//--- hdl/inst_predecode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_predecode (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  logic              inst_valid,
	input  rv_isa_pkg::inst_u inst,
	output logic              pd_valid,
	output rv_isa_pkg::inst_u pd_inst,
	output logic              pd_jal,
	output logic              pd_jalr,
	output logic              pd_branch,
	output logic              pd_sys,
	output logic              pd_ecall,
	output logic              pd_mret
);

	logic take;

	assign take = inst_valid & ~stall;

	// flush beats stall
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pd_valid <= 1'b0;
		end else if (!stall) begin
			pd_valid <= inst_valid;
		end
	end

	// flags resolved here to keep the decoder path short
	always_ff @(posedge clk) begin
		if (take) begin
			pd_inst   <= inst;
			pd_jal    <= (inst.r.opcode == rv_isa_pkg::OP_JAL);
			pd_jalr   <= (inst.r.opcode == rv_isa_pkg::OP_JALR);
			pd_branch <= (inst.r.opcode == rv_isa_pkg::OP_BRANCH);
			pd_sys    <= (inst.r.opcode == rv_isa_pkg::OP_SYSTEM);
			pd_ecall  <= (inst == rv_isa_pkg::INST_ECALL);
			pd_mret   <= (inst == rv_isa_pkg::INST_MRET);
		end
	end

endmodule

`default_nettype wire

//--- hdl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

	// alu operation bus, one hot except bru and muldiv bits
	localparam int ALU_OPT_W       = 16;
	localparam int ALU_ADD         = 0;
	localparam int ALU_SUB         = 1;
	localparam int ALU_SLL         = 2;
	localparam int ALU_SLT         = 3;
	localparam int ALU_SLTU        = 4;
	localparam int ALU_XOR         = 5;
	localparam int ALU_SRL         = 6;
	localparam int ALU_SRA         = 7;
	localparam int ALU_OR          = 8;
	localparam int ALU_AND         = 9;
	localparam int ALU_PC          = 10;
	// inverts the compare result for bne, bge, bgeu
	localparam int ALU_BRU         = 11;
	localparam int ALU_MUL         = 12;
	localparam int ALU_DIV         = 13;
	localparam int ALU_MULDIV_BIT0 = 14;
	localparam int ALU_MULDIV_BIT1 = 15;

	// csr operation bus
	localparam int CSR_OPT_W = 6;
	localparam int CSR_ECALL = 0;
	localparam int CSR_MRET  = 1;
	localparam int CSR_ZIMM  = 2;
	localparam int CSR_01    = 3;
	localparam int CSR_10    = 4;
	localparam int CSR_11    = 5;

	// bit 1 picks pc+imm over pc+4, bit 0 picks src2 over imm
	localparam int SRC_SEL_W = 2;
	localparam logic [SRC_SEL_W-1:0] SRC_SEL_4_IMM    = 2'd0;
	localparam logic [SRC_SEL_W-1:0] SRC_SEL_4_SRC2   = 2'd1;
	localparam logic [SRC_SEL_W-1:0] SRC_SEL_IMM_IMM  = 2'd2;
	localparam logic [SRC_SEL_W-1:0] SRC_SEL_IMM_SRC2 = 2'd3;

	// bit 0 load, bit 1 store
	localparam int LSU_OPT_W = 2;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN  = 32;
	localparam int REG_W = 5;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// system words matched in full
	localparam logic [XLEN-1:0] INST_ECALL = 32'h0000_0073;
	localparam logic [XLEN-1:0] INST_MRET  = 32'h3020_0073;

	// one instruction word seen through each base format
	typedef union packed {
		struct packed {
			logic [6:0]       funct7;
			logic [REG_W-1:0] rs2;
			logic [REG_W-1:0] rs1;
			logic [2:0]       funct3;
			logic [REG_W-1:0] rd;
			logic [6:0]       opcode;
		} r;
		struct packed {
			logic [11:0]      imm_11_0;
			logic [REG_W-1:0] rs1;
			logic [2:0]       funct3;
			logic [REG_W-1:0] rd;
			logic [6:0]       opcode;
		} i;
		struct packed {
			logic [6:0]       imm_11_5;
			logic [REG_W-1:0] rs2;
			logic [REG_W-1:0] rs1;
			logic [2:0]       funct3;
			logic [4:0]       imm_4_0;
			logic [6:0]       opcode;
		} s;
		struct packed {
			logic             imm_12;
			logic [5:0]       imm_10_5;
			logic [REG_W-1:0] rs2;
			logic [REG_W-1:0] rs1;
			logic [2:0]       funct3;
			logic [3:0]       imm_4_1;
			logic             imm_11;
			logic [6:0]       opcode;
		} b;
		struct packed {
			logic [19:0]      imm_31_12;
			logic [REG_W-1:0] rd;
			logic [6:0]       opcode;
		} u;
		struct packed {
			logic             imm_20;
			logic [9:0]       imm_10_1;
			logic             imm_11;
			logic [7:0]       imm_19_12;
			logic [REG_W-1:0] rd;
			logic [6:0]       opcode;
		} j;
	} inst_u;

endpackage

`default_nettype wire
